/* common/aes_ctr_settings.svh */
// Sizing of the CTR-mode counter path
// Slice size times slice count must give the 128-bit block,
// and the index width must cover the slice count

`ifndef AES_CTR_SETTINGS_SVH
`define AES_CTR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Counter slicing
////////////////////////////////////////////////////////////

// Bits incremented per clock cycle
`define CTR_SLICE_SIZE 16

// Slices per 128-bit counter block
`define CTR_NUM_SLICES 8

// Width of a slice index
`define CTR_SLICE_IDX_W 3

// Width of the sparse two-valued encoding, one FSM rail per bit
`define SP2V_WIDTH 3

`endif

/* common/aes_ctr_pkg.sv */
// Types shared by the counter path of the CTR-mode engine
// The sparse encoding only knows two legal words, all others are errors
// The counter block is 128 bits, big-endian, byte 15 least significant

`include "aes_ctr_settings.svh"

`default_nettype none

package aes_ctr_pkg;

  ////////////////////////////////////////////////////////////
  // Sparse two-valued signals
  ////////////////////////////////////////////////////////////

  // Logic high and logic low, Hamming distance of three
  typedef enum logic [`SP2V_WIDTH-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Bits set in SP2V_HIGH
  // A set bit means the matching rail is active high
  parameter logic [`SP2V_WIDTH-1:0] SP2V_LOGIC_HIGH = 3'b011;

  ////////////////////////////////////////////////////////////
  // Counter block
  ////////////////////////////////////////////////////////////

  // Same 128 bits seen two ways
  typedef union packed {
    // Byte view, for byte order reversal
    logic [(`CTR_NUM_SLICES*`CTR_SLICE_SIZE/8)-1:0][7:0] bytes;
    // Slice view, for slice indexing
    logic [`CTR_NUM_SLICES-1:0][`CTR_SLICE_SIZE-1:0]     slices;
  } ctr_blk_t;

endpackage

`default_nettype wire

/* aes_ctr/aes_ctr_fsm.sv */
// Single rail of the redundant slice-increment FSM
// With RAIL_ACTIVE_LOW set, incr_i, ready_o and ctr_we_o are low-active
// The error state is terminal, only reset leaves it

`include "aes_ctr_settings.svh"

`default_nettype none

module aes_ctr_fsm #(
  parameter bit RAIL_ACTIVE_LOW = 1'b0
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        incr_i,
  input  logic                        incr_err_i,
  input  logic                        mr_err_i,
  input  logic [`CTR_SLICE_SIZE-1:0]  ctr_slice_i,

  output logic                        ready_o,
  output logic                        alert_o,
  output logic [`CTR_SLICE_IDX_W-1:0] ctr_slice_idx_o,
  output logic [`CTR_SLICE_SIZE-1:0]  ctr_slice_o,
  output logic                        ctr_we_o
);

  // State codes, 2'b00 is illegal and falls into error
  localparam logic [1:0] ST_IDLE  = 2'b01;
  localparam logic [1:0] ST_INCR  = 2'b10;
  localparam logic [1:0] ST_ERROR = 2'b11;

  // Most significant slice
  localparam logic [`CTR_SLICE_IDX_W-1:0] LAST_IDX =
    `CTR_SLICE_IDX_W'(`CTR_NUM_SLICES - 1);

  logic [1:0]                  state_q, state_d;
  logic [`CTR_SLICE_IDX_W-1:0] idx_q, idx_d;
  logic [`CTR_SLICE_SIZE-1:0]  slice_sum;
  logic                        incr;
  logic                        ready;
  logic                        we;

  // Undo rail polarity on the way in
  assign incr = incr_i ^ RAIL_ACTIVE_LOW;

  // Slice plus one, a zero result means carry out
  assign slice_sum = ctr_slice_i + `CTR_SLICE_SIZE'(1);

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    ready   = 1'b0;
    we      = 1'b0;

    case (state_q)
      ST_IDLE: begin
        ready = 1'b1;
        // Always start at the least significant slice
        idx_d = '0;
        if (incr) begin
          state_d = ST_INCR;
        end
      end
      ST_INCR: begin
        we    = 1'b1;
        idx_d = idx_q + 1'b1;
        // No carry, or nothing left to carry into
        if (slice_sum != '0 || idx_q == LAST_IDX) begin
          state_d = ST_IDLE;
        end
      end
      ST_ERROR: begin
        // Terminal
      end
      default: begin
        state_d = ST_ERROR;
      end
    endcase

    // Bad input encoding or rail disagreement wins over everything
    if (incr_err_i || mr_err_i) begin
      state_d = ST_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  // Rail polarity applied again on the way out
  assign ready_o         = ready ^ RAIL_ACTIVE_LOW;
  assign ctr_we_o        = we ^ RAIL_ACTIVE_LOW;
  assign alert_o         = (state_q == ST_ERROR);
  assign ctr_slice_idx_o = idx_q;
  assign ctr_slice_o     = slice_sum;

endmodule

`default_nettype wire

/* aes_ctr/aes_ctr.sv */
// Counter logic of the CTR-mode engine, one slice per cycle
// incr_i is only sampled while ready_o is SP2V_HIGH
// Any invalid incr_i or rail disagreement ends in a terminal error

`include "aes_ctr_settings.svh"

`default_nettype none

module aes_ctr import aes_ctr_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  sp2v_e                       incr_i,
  input  ctr_blk_t                    ctr_i,

  output sp2v_e                       ready_o,
  output logic                        alert_o,
  output ctr_blk_t                    ctr_o,
  output sp2v_e [`CTR_NUM_SLICES-1:0] ctr_we_o
);

  // Swap byte order so slice 0 becomes least significant
  function automatic ctr_blk_t rev_bytes(ctr_blk_t blk);
    ctr_blk_t res;
    for (int i = 0; i < $bits(ctr_blk_t) / 8; i++) begin
      res.bytes[i] = blk.bytes[$bits(ctr_blk_t) / 8 - 1 - i];
    end
    return res;
  endfunction

  // Swap order of the slice enables
  function automatic sp2v_e [`CTR_NUM_SLICES-1:0] rev_we(sp2v_e [`CTR_NUM_SLICES-1:0] we);
    sp2v_e [`CTR_NUM_SLICES-1:0] res;
    for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
      res[i] = we[`CTR_NUM_SLICES - 1 - i];
    end
    return res;
  endfunction

  ctr_blk_t                    ctr_i_rev;
  ctr_blk_t                    ctr_o_rev;
  sp2v_e [`CTR_NUM_SLICES-1:0] ctr_we_rev;
  sp2v_e                       ctr_we;
  logic [`CTR_SLICE_IDX_W-1:0] slice_idx;
  logic [`CTR_SLICE_SIZE-1:0]  slice_cur;
  logic [`CTR_SLICE_SIZE-1:0]  slice_new;
  logic                        incr_err;
  logic                        mr_err;

  // One bit per rail
  logic [`SP2V_WIDTH-1:0]      sp_ready;
  logic [`SP2V_WIDTH-1:0]      sp_we;
  logic [`SP2V_WIDTH-1:0]      mr_alert;
  logic [`SP2V_WIDTH-1:0][`CTR_SLICE_IDX_W-1:0] mr_idx;
  logic [`SP2V_WIDTH-1:0][`CTR_SLICE_SIZE-1:0]  mr_slice;

  ////////////////////////////////////////////////////////////
  // Inputs
  ////////////////////////////////////////////////////////////

  assign ctr_i_rev = rev_bytes(ctr_i);
  assign slice_cur = ctr_i_rev.slices[slice_idx];

  // Only the two legal words pass
  assign incr_err = (incr_i != SP2V_HIGH) && (incr_i != SP2V_LOW);

  ////////////////////////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `SP2V_WIDTH; i++) begin : gen_rail
    aes_ctr_fsm #(
      .RAIL_ACTIVE_LOW ( ~SP2V_LOGIC_HIGH[i] )
    ) u_aes_ctr_fsm (
      .clk_i           ( clk_i       ),
      .rst_n_i         ( rst_n_i     ),
      .incr_i          ( incr_i[i]   ),
      .incr_err_i      ( incr_err    ),
      .mr_err_i        ( mr_err      ),
      .ctr_slice_i     ( slice_cur   ),
      .ready_o         ( sp_ready[i] ),
      .alert_o         ( mr_alert[i] ),
      .ctr_slice_idx_o ( mr_idx[i]   ),
      .ctr_slice_o     ( mr_slice[i] ),
      .ctr_we_o        ( sp_we[i]    )
    );
  end

  // Rail bits already form the sparse word
  assign ready_o = sp2v_e'(sp_ready);
  assign ctr_we  = sp2v_e'(sp_we);
  assign alert_o = |mr_alert;

  // OR all rails, then every rail must match the result
  always_comb begin
    slice_idx = '0;
    slice_new = '0;
    mr_err    = 1'b0;
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      slice_idx |= mr_idx[i];
      slice_new |= mr_slice[i];
    end
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      if (mr_idx[i] != slice_idx || mr_slice[i] != slice_new) begin
        mr_err = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Splice the new slice into the block
  always_comb begin
    ctr_o_rev                   = ctr_i_rev;
    ctr_o_rev.slices[slice_idx] = slice_new;
  end

  // Enable only the current slice
  always_comb begin
    for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
      ctr_we_rev[i] = SP2V_LOW;
    end
    ctr_we_rev[slice_idx] = ctr_we;
  end

  assign ctr_o    = rev_bytes(ctr_o_rev);
  assign ctr_we_o = rev_we(ctr_we_rev);

endmodule

`default_nettype wire

/* logic/aes_ctr_reg.sv */
// Counter block register with per-slice sparse write enables
// load_i is only pulsed while the counter logic is ready
// Alert holds until reset once set

`include "aes_ctr_settings.svh"

`default_nettype none

module aes_ctr_reg import aes_ctr_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        load_i,
  input  ctr_blk_t                    iv_i,
  input  ctr_blk_t                    ctr_nxt_i,
  input  sp2v_e [`CTR_NUM_SLICES-1:0] ctr_we_i,
  input  logic                        ctr_alert_i,

  output ctr_blk_t                    ctr_o,
  output logic                        alert_o
);

  ctr_blk_t ctr_q;
  logic     alert_q;
  logic     we_err;

  // Any enable outside the two legal words
  always_comb begin
    we_err = 1'b0;
    for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
      if (ctr_we_i[i] != SP2V_HIGH && ctr_we_i[i] != SP2V_LOW) begin
        we_err = 1'b1;
      end
    end
  end

  // Load wins, else only enabled slices change
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctr_q <= '0;
    end else if (load_i) begin
      ctr_q <= iv_i;
    end else begin
      for (int i = 0; i < `CTR_NUM_SLICES; i++) begin
        if (ctr_we_i[i] == SP2V_HIGH) begin
          ctr_q.slices[i] <= ctr_nxt_i.slices[i];
        end
      end
    end
  end

  // Sticky alert
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | we_err | ctr_alert_i;
    end
  end

  assign ctr_o   = ctr_q;
  assign alert_o = alert_q;

endmodule

`default_nettype wire

/* logic/aes_ctr_unit.sv */
// Counter path of the CTR-mode engine, 128-bit big-endian block
// Pulse load_i only while ready_o is SP2V_HIGH
// incr_i is a sparse level, ignored while busy
// alert_o holds until reset

`include "aes_ctr_settings.svh"

`default_nettype none

module aes_ctr_unit import aes_ctr_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     load_i,
  input  ctr_blk_t iv_i,
  input  sp2v_e    incr_i,

  output sp2v_e    ready_o,
  output logic     alert_o,
  output ctr_blk_t ctr_o
);

  ctr_blk_t                    ctr_q;
  ctr_blk_t                    ctr_nxt;
  sp2v_e [`CTR_NUM_SLICES-1:0] ctr_we;
  logic                        ctr_alert;

  ////////////////////////////////////////////////////////////
  // Increment logic
  ////////////////////////////////////////////////////////////

  aes_ctr u_aes_ctr (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .incr_i   ( incr_i    ),
    .ctr_i    ( ctr_q     ),
    .ready_o  ( ready_o   ),
    .alert_o  ( ctr_alert ),
    .ctr_o    ( ctr_nxt   ),
    .ctr_we_o ( ctr_we    )
  );

  // Block storage and sticky alert
  aes_ctr_reg u_aes_ctr_reg (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .load_i      ( load_i    ),
    .iv_i        ( iv_i      ),
    .ctr_nxt_i   ( ctr_nxt   ),
    .ctr_we_i    ( ctr_we    ),
    .ctr_alert_i ( ctr_alert ),
    .ctr_o       ( ctr_q     ),
    .alert_o     ( alert_o   )
  );

  assign ctr_o = ctr_q;

endmodule

`default_nettype wire

/* verif/aes_ctr_props.sv */
// Concurrent checks on the counter path top level
// All checks are off while reset is asserted

`default_nettype none

module aes_ctr_props import aes_ctr_pkg::*; (
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     load_i,
  input sp2v_e    ready_i,
  input logic     alert_i,
  input ctr_blk_t ctr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Rails agree on ready unless an error was flagged
  ready_valid_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !alert_i |-> (ready_i == SP2V_HIGH || ready_i == SP2V_LOW))
    else $error("ready_o holds an invalid sparse word");

  // Sticky alert
  alert_sticky_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alert_i |=> alert_i)
    else $error("alert_o fell without a reset");

  // Idle and no load, counter holds
  ctr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ready_i == SP2V_HIGH && !load_i) |=> $stable(ctr_i))
    else $error("ctr_o changed while idle");

endmodule

bind aes_ctr_unit aes_ctr_props u_aes_ctr_props (
  .clk_i   ( clk_i   ),
  .rst_n_i ( rst_n_i ),
  .load_i  ( load_i  ),
  .ready_i ( ready_o ),
  .alert_i ( alert_o ),
  .ctr_i   ( ctr_o   )
);

`default_nettype wire

/* verif/aes_ctr_tb.sv */
// Directed testbench for the CTR-mode counter path
// Inputs change on the rising edge and checks run on the falling edge
// Each wait gives up after 20 cycles and ends the run

`default_nettype none

module aes_ctr_tb import aes_ctr_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_CYCLES = 20;

  logic        clk_i;
  logic        rst_n_i;
  logic        load_i;
  ctr_blk_t    iv_i;
  sp2v_e       incr_i;
  sp2v_e       ready_o;
  logic        alert_o;
  ctr_blk_t    ctr_o;
  logic [31:0] lfsr_state;

  aes_ctr_unit u_dut (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .load_i  ( load_i  ),
    .iv_i    ( iv_i    ),
    .incr_i  ( incr_i  ),
    .ready_o ( ready_o ),
    .alert_o ( alert_o ),
    .ctr_o   ( ctr_o   )
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////////////////////////

  // Big-endian block plus one modulo 2^128
  function automatic ctr_blk_t ref_incr(ctr_blk_t blk);
    logic [127:0] val;
    ctr_blk_t     res;
    // Byte 15 ends up as the least significant byte
    val = {<<8{blk}};
    val = val + 128'd1;
    res = {<<8{val}};
    return res;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // One LFSR step per bit
  function automatic logic [127:0] rand_bits(int n);
    logic [127:0] res;
    res = '0;
    for (int i = 0; i < n; i++) begin
      res = {res[126:0], lfsr_step()};
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Error handling and compares
  ////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_ctr(string name, ctr_blk_t exp, ctr_blk_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_sp2v(string name, sp2v_e exp, sp2v_e act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers and waits
  ////////////////////////////////////////////////////////////

  // Reset held for 10 cycles
  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i <= 1'b0;
    incr_i  <= SP2V_LOW;
    load_i  <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
  endtask

  task automatic wait_ready(string name);
    for (int c = 0; c < WAIT_CYCLES; c++) begin
      @(negedge clk_i);
      if (ready_o == SP2V_HIGH) begin
        return;
      end
    end
    $display("ready_o did not return to SP2V_HIGH within %0d cycles in %s",
             WAIT_CYCLES, name);
    stop_run();
  endtask

  task automatic wait_alert(string name);
    for (int c = 0; c < WAIT_CYCLES; c++) begin
      @(negedge clk_i);
      if (alert_o) begin
        return;
      end
    end
    $display("alert_o did not rise within %0d cycles in %s", WAIT_CYCLES, name);
    stop_run();
  endtask

  // Load pulse and the block shows one cycle later
  task automatic load_iv(ctr_blk_t iv);
    @(posedge clk_i);
    load_i <= 1'b1;
    iv_i   <= iv;
    @(posedge clk_i);
    load_i <= 1'b0;
    @(negedge clk_i);
  endtask

  // One cycle of SP2V_HIGH and then wait for the end of the increment
  task automatic pulse_incr(string name);
    @(posedge clk_i);
    incr_i <= SP2V_HIGH;
    @(posedge clk_i);
    incr_i <= SP2V_LOW;
    wait_ready(name);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_sp2v("test_reset ready", SP2V_HIGH, ready_o);
    check_bit("test_reset alert", 1'b0, alert_o);
    check_ctr("test_reset ctr", '0, ctr_o);
  endtask

  task automatic test_single();
    ctr_blk_t iv;
    // Low slice is not all ones so no carry
    iv = 128'h1234_ccdd_8899_aabb_4455_6677_0011_2233;
    load_iv(iv);
    check_ctr("test_single load", iv, ctr_o);
    pulse_incr("test_single");
    check_ctr("test_single", ref_incr(iv), ctr_o);
    check_bit("test_single alert", 1'b0, alert_o);
  endtask

  task automatic test_carry();
    ctr_blk_t base;
    ctr_blk_t iv;
    int       ones [3];
    base = 128'h0123_4567_89ab_cdef_0f1e_2d3c_4b5a_6978;
    ones = '{1, 3, 8};
    foreach (ones[k]) begin
      // Low slices sit at the top of the word
      iv = base | ({128{1'b1}} << (128 - 16 * ones[k]));
      load_iv(iv);
      pulse_incr("test_carry");
      check_ctr("test_carry", ref_incr(iv), ctr_o);
    end
    // All ones wraps
    check_ctr("test_carry wrap", '0, ctr_o);
    check_bit("test_carry alert", 1'b0, alert_o);
  endtask

  task automatic test_random();
    ctr_blk_t iv;
    ctr_blk_t exp;
    int       num;
    for (int t = 0; t < 20; t++) begin
      iv  = rand_bits(128);
      num = 1 + int'(rand_bits(2) % 3);
      load_iv(iv);
      check_ctr("test_random load", iv, ctr_o);
      exp = iv;
      for (int k = 0; k < num; k++) begin
        pulse_incr("test_random");
        exp = ref_incr(exp);
        check_ctr("test_random", exp, ctr_o);
      end
    end
  endtask

  task automatic test_idle_low();
    ctr_blk_t iv;
    iv = rand_bits(128);
    load_iv(iv);
    @(posedge clk_i);
    incr_i <= SP2V_LOW;
    for (int c = 0; c < 8; c++) begin
      @(negedge clk_i);
      check_sp2v("test_idle_low ready", SP2V_HIGH, ready_o);
      check_ctr("test_idle_low ctr", iv, ctr_o);
    end
    check_bit("test_idle_low alert", 1'b0, alert_o);
  endtask

  task automatic test_bad_encoding();
    @(posedge clk_i);
    incr_i <= sp2v_e'(3'b111);
    @(posedge clk_i);
    incr_i <= SP2V_LOW;
    wait_alert("test_bad_encoding");
    // Terminal until reset
    for (int c = 0; c < 6; c++) begin
      @(negedge clk_i);
      check_bit("test_bad_encoding alert", 1'b1, alert_o);
      check_sp2v("test_bad_encoding ready", SP2V_LOW, ready_o);
    end
    apply_reset();
    test_reset();
  endtask

  initial begin
    rst_n_i    = 1'b0;
    load_i     = 1'b0;
    iv_i       = '0;
    incr_i     = SP2V_LOW;
    lfsr_state = 32'h1bb9;
    apply_reset();
    test_reset();
    test_single();
    test_carry();
    test_random();
    test_idle_low();
    test_bad_encoding();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/aes_ctr_pkg.sv
aes_ctr/aes_ctr_fsm.sv
aes_ctr/aes_ctr.sv
logic/aes_ctr_reg.sv
logic/aes_ctr_unit.sv
verif/aes_ctr_props.sv
verif/aes_ctr_tb.sv

/* Makefile */
# Verilator build and run of the counter path testbench

TOP := aes_ctr_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
